//--- verilog.f
+incdir+design
design/life_pkg.sv
design/grid_if.sv
design/row_ram.sv
design/cmd_front.sv
design/preset_rom.sv
design/life_row_rule.sv
design/life_engine.sv
design/life_top.sv
verif/life_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --timing
TOP      = life_tb
FILELIST = verilog.f
BUILD    = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# Pass only when the pass line shows up in the simulator output
sim:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -qx "test passed"

clean:
	rm -rf $(BUILD)

//--- verif/life_tb.sv
`timescale 1ns/1ps
`include "life_config.svh"

module life_tb;
    localparam int          CLK_PERIOD = 20;
    localparam int          MAX_WAIT   = 400;   // Wait bound in cycles
    localparam int          ROWS       = `LIFE_ROWS;
    localparam int          COLS       = `LIFE_COLS;
    localparam logic [31:0] SEED       = 32'h06ea91d8;

    logic                   clk;
    logic                   reset_n;
    logic                   preset_load;
    logic [2:0]             preset_sel;
    logic                   toggle;
    logic [`LIFE_COL_W-1:0] cell_x;
    logic [`LIFE_ROW_W-1:0] cell_y;
    logic                   step;
    logic                   rd_en;
    logic [`LIFE_ROW_W-1:0] rd_row;
    logic                   busy;
    logic                   rd_valid;
    logic [`LIFE_COLS-1:0]  rd_data;

    logic [COLS-1:0] model [ROWS];   // Reference grid with column 0 at the MSB

    life_top u_life_top (
        .clk         (clk),
        .reset_n     (reset_n),
        .preset_load (preset_load),
        .preset_sel  (preset_sel),
        .toggle      (toggle),
        .cell_x      (cell_x),
        .cell_y      (cell_y),
        .step        (step),
        .rd_en       (rd_en),
        .rd_row      (rd_row),
        .busy        (busy),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // 30 steps of 200 cycles each
    initial begin
        #(30 * 200 * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("test failed");
        $fatal(1);
    end

    task automatic check(input string name, input logic [COLS-1:0] expected,
                         input logic [COLS-1:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    function automatic logic cell_at(input int r, input int c);
        if (r < 0 || r >= ROWS || c < 0 || c >= COLS) begin
            return 1'b0;   // Outside the grid is dead
        end
        return model[r][COLS-1-c];
    endfunction

    task automatic put_run(input int r, input int first, input int width,
                           input logic [6:0] bits);
        for (int k = 0; k < width; k++) begin
            model[r][COLS-1-first-k] = bits[width-1-k];
        end
    endtask

    task automatic model_preset(input int p);
        for (int r = 0; r < ROWS; r++) begin
            model[r] = '0;
        end
        case (p)
            1: begin
                put_run(0, 1, 1, 7'b1);
                put_run(1, 2, 2, 7'b11);
                put_run(2, 1, 2, 7'b11);
            end
            2: begin
                put_run(13, 17, 5, 7'b10101);
                for (int r = 14; r <= 16; r++) begin
                    put_run(r, 17, 5, 7'b10001);
                end
                put_run(17, 17, 5, 7'b10101);
            end
            3: begin
                put_run(13, 17, 5, 7'b11011);
                put_run(14, 17, 5, 7'b11011);
                put_run(15, 17, 5, 7'b01010);
                put_run(16, 16, 7, 7'b1010101);
                put_run(17, 16, 7, 7'b1010101);
                put_run(18, 16, 7, 7'b1100011);
            end
            default: ;   // Clear
        endcase
    endtask

    task automatic model_step();
        logic [COLS-1:0] nxt [ROWS];
        int              n;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                n = 0;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        if (dr != 0 || dc != 0) begin
                            n += int'(cell_at(r + dr, c + dc));
                        end
                    end
                end
                nxt[r][COLS-1-c] = (n == 3) || (n == 2 && cell_at(r, c));
            end
        end
        model = nxt;
    endtask

    // Strobes for one cycle and returns once the engine has picked the command up
    task automatic issue(input logic do_preset, input logic do_toggle, input logic do_step,
                         input logic do_read, input int sel, input int x, input int y,
                         input int rrow);
        @(posedge clk);
        preset_load <= do_preset;
        toggle      <= do_toggle;
        step        <= do_step;
        rd_en       <= do_read;
        preset_sel  <= 3'(sel);
        cell_x      <= 6'(x);
        cell_y      <= 5'(y);
        rd_row      <= 5'(rrow);
        @(posedge clk);
        preset_load <= 1'b0;
        toggle      <= 1'b0;
        step        <= 1'b0;
        rd_en       <= 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy) begin
            n++;
            if (n > MAX_WAIT) begin
                $display("Timeout: busy stayed high for %0d cycles", MAX_WAIT);
                $display("test failed");
                $fatal(1);
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic wait_rd_valid(output logic [COLS-1:0] data);
        int n;
        n = 0;
        @(negedge clk);
        while (!rd_valid) begin
            n++;
            if (n > MAX_WAIT) begin
                $display("Timeout: no read data came back within %0d cycles", MAX_WAIT);
                $display("test failed");
                $fatal(1);
            end else begin
                @(negedge clk);
            end
        end
        data = rd_data;
    endtask

    task automatic load_preset(input int p);
        issue(1'b1, 1'b0, 1'b0, 1'b0, p, 0, 0, 0);
        wait_idle();
        model_preset(p);
    endtask

    task automatic toggle_cell(input int x, input int y);
        issue(1'b0, 1'b1, 1'b0, 1'b0, 0, x, y, 0);
        wait_idle();
        model[y][COLS-1-x] = ~model[y][COLS-1-x];
    endtask

    task automatic step_grid();
        issue(1'b0, 1'b0, 1'b1, 1'b0, 0, 0, 0, 0);
        wait_idle();
        model_step();
    endtask

    // The valid pulse lasts one cycle and busy drops right after it
    task automatic read_row(input int r, output logic [COLS-1:0] data);
        issue(1'b0, 1'b0, 1'b0, 1'b1, 0, 0, 0, r);
        wait_rd_valid(data);
        @(negedge clk);
        check("rd_valid pulse width", 40'd0, 40'(rd_valid));
        check("busy after read", 40'd0, 40'(busy));
    endtask

    task automatic compare_grid(input string name);
        logic [COLS-1:0] data;
        for (int r = 0; r < ROWS; r++) begin
            read_row(r, data);
            check($sformatf("%s row %0d", name, r), model[r], data);
        end
    endtask

    task automatic test_reset_clear();
        @(negedge clk);
        check("reset busy", 40'd0, 40'(busy));
        check("reset rd_valid", 40'd0, 40'(rd_valid));
        check("reset rd_data", 40'd0, rd_data);
        load_preset(0);
        compare_grid("clear preset");
    endtask

    task automatic test_presets();
        load_preset(1);
        compare_grid("glider preset");
        load_preset(2);
        compare_grid("exploder preset");
        load_preset(3);
        compare_grid("tumbler preset");
    endtask

    task automatic test_toggles();
        logic [COLS-1:0] data;
        int              x;
        int              y;
        load_preset(0);
        toggle_cell(0, 29);
        read_row(29, data);
        check("corner col 0 row 29", 40'h80_0000_0000, data);
        toggle_cell(39, 0);
        read_row(0, data);
        check("corner col 39 row 0", 40'h00_0000_0001, data);
        for (int i = 0; i < 8; i++) begin
            x = int'($urandom % COLS);
            y = int'($urandom % ROWS);
            toggle_cell(x, y);
        end
        compare_grid("random toggles");
        x = int'($urandom % COLS);
        y = int'($urandom % ROWS);
        toggle_cell(x, y);
        toggle_cell(x, y);
        read_row(y, data);
        check("double toggle", model[y], data);
    endtask

    task automatic test_oscillators();
        logic [COLS-1:0] data;
        load_preset(0);
        toggle_cell(10, 5);
        toggle_cell(10, 6);
        toggle_cell(10, 7);
        step_grid();
        read_row(6, data);
        check("blinker horizontal", 40'h00_7000_0000, data);   // Columns 9 to 11
        compare_grid("blinker step 1");
        step_grid();
        compare_grid("blinker step 2");
        load_preset(2);
        for (int i = 1; i <= 3; i++) begin
            step_grid();
            compare_grid($sformatf("exploder step %0d", i));
        end
    endtask

    task automatic test_random_grid();
        load_preset(0);
        // Short lines on the edges so that births happen there too
        toggle_cell(0, 10);
        toggle_cell(0, 11);
        toggle_cell(0, 12);
        toggle_cell(37, 29);
        toggle_cell(38, 29);
        toggle_cell(39, 29);
        for (int i = 0; i < 54; i++) begin
            toggle_cell(int'($urandom % COLS), int'($urandom % ROWS));
        end
        step_grid();
        compare_grid("random grid step");
    endtask

    task automatic test_busy_drop();
        load_preset(1);
        issue(1'b0, 1'b0, 1'b1, 1'b0, 0, 0, 0, 0);
        @(negedge clk);
        check("busy during step", 40'd1, 40'(busy));
        issue(1'b0, 1'b1, 1'b0, 1'b0, 0, 5, 5, 0);   // Must be dropped
        wait_idle();
        model_step();
        compare_grid("toggle during step");
        issue(1'b1, 1'b0, 1'b1, 1'b1, 2, 0, 0, 0);
        repeat (40) begin
            @(negedge clk);
            check("no read beside preset", 40'd0, 40'(rd_valid));
        end
        wait_idle();
        model_preset(2);
        compare_grid("preset priority");
    endtask

    initial begin
        void'($urandom(SEED));
        reset_n     = 1'b0;
        preset_load = 1'b0;
        preset_sel  = '0;
        toggle      = 1'b0;
        cell_x      = '0;
        cell_y      = '0;
        step        = 1'b0;
        rd_en       = 1'b0;
        rd_row      = '0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;

        test_reset_clear();
        test_presets();
        test_toggles();
        test_oscillators();
        test_random_grid();
        test_busy_drop();

        $display("test passed");
        $finish;
    end

endmodule

//--- design/life_top.sv
`timescale 1ns/1ps
`include "life_config.svh"

module life_top (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   preset_load,
    input  logic [2:0]             preset_sel,
    input  logic                   toggle,
    input  logic [`LIFE_COL_W-1:0] cell_x,
    input  logic [`LIFE_ROW_W-1:0] cell_y,
    input  logic                   step,
    input  logic                   rd_en,
    input  logic [`LIFE_ROW_W-1:0] rd_row,
    output logic                   busy,
    output logic                   rd_valid,
    output logic [`LIFE_COLS-1:0]  rd_data
);
    logic                cmd_valid;
    life_pkg::cmd_t      cmd;
    life_pkg::preset_t   preset;
    life_pkg::col_addr_t col;
    life_pkg::row_addr_t row;

    grid_if cur_bus ();   // Live grid
    grid_if nxt_bus ();   // Next generation

    cmd_front u_cmd_front (
        .clk         (clk),
        .reset_n     (reset_n),
        .preset_load (preset_load),
        .toggle      (toggle),
        .step        (step),
        .rd_en       (rd_en),
        .preset_sel  (life_pkg::preset_t'(preset_sel)),
        .cell_x      (cell_x),
        .cell_y      (cell_y),
        .rd_row      (rd_row),
        .busy        (busy),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .preset      (preset),
        .col         (col),
        .row         (row)
    );

    life_engine u_life_engine (
        .clk       (clk),
        .reset_n   (reset_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .preset    (preset),
        .col       (col),
        .row       (row),
        .busy      (busy),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .cur       (cur_bus),
        .nxt       (nxt_bus)
    );

    row_ram u_cur_ram (
        .clk (clk),
        .bus (cur_bus)
    );

    row_ram u_nxt_ram (
        .clk (clk),
        .bus (nxt_bus)
    );

endmodule

//--- design/life_engine.sv
`timescale 1ns/1ps
`include "life_config.svh"

module life_engine (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                cmd_valid,
    input  life_pkg::cmd_t      cmd,
    input  life_pkg::preset_t   preset,
    input  life_pkg::col_addr_t col,
    input  life_pkg::row_addr_t row,
    output logic                busy,
    output logic                rd_valid,
    output life_pkg::row_t      rd_data,
    grid_if.master              cur,
    grid_if.master              nxt
);
    localparam life_pkg::row_addr_t LAST_ROW = life_pkg::row_addr_t'(`LIFE_ROWS - 1);
    localparam life_pkg::row_addr_t ROW_END  = life_pkg::row_addr_t'(`LIFE_ROWS);

    typedef enum logic [3:0] {
        S_IDLE,
        S_PRESET,
        S_TGL_RD,
        S_TGL_WAIT,
        S_TGL_WR,
        S_STEP_FETCH,
        S_STEP_WRITE,
        S_COPY,
        S_READ
    } state_t;

    state_t              state;
    life_pkg::row_addr_t cnt;     // Row under work
    logic [1:0]          phase;   // Fetch slot within a row
    life_pkg::row_t      win_above;
    life_pkg::row_t      win_mid;
    life_pkg::row_t      win_below;
    life_pkg::row_t      rom_word;
    life_pkg::row_t      rule_word;
    life_pkg::row_t      toggle_mask;

    preset_rom u_preset_rom (
        .preset  (preset),
        .row     (cnt),
        .pattern (rom_word)
    );

    life_row_rule u_row_rule (
        .above  (win_above),
        .middle (win_mid),
        .below  (win_below),
        .next   (rule_word)
    );

    assign toggle_mask = life_pkg::row_t'(1) << (`LIFE_COLS - 1 - col);
    assign busy        = (state != S_IDLE) || rd_valid;

    always_comb begin
        cur.addr  = row;          // Idle reads the operand row, ready for a read command
        cur.wdata = cur.rdata ^ toggle_mask;
        cur.wen   = 1'b0;
        nxt.addr  = cnt;
        nxt.wdata = rule_word;
        nxt.wen   = 1'b0;
        case (state)
            S_PRESET: begin
                cur.addr  = cnt;
                cur.wdata = rom_word;
                cur.wen   = 1'b1;
            end
            S_TGL_WR: cur.wen = 1'b1;
            S_STEP_FETCH: begin
                case (phase)
                    2'd0:    cur.addr = (cnt == '0) ? cnt : cnt - 1'b1;
                    2'd1:    cur.addr = cnt;
                    default: cur.addr = (cnt == LAST_ROW) ? cnt : cnt + 1'b1;
                endcase
            end
            S_STEP_WRITE: nxt.wen = 1'b1;
            S_COPY: begin
                // Read row cnt while writing back row cnt-1
                nxt.addr  = (cnt == ROW_END) ? LAST_ROW : cnt;
                cur.addr  = cnt - 1'b1;
                cur.wdata = nxt.rdata;
                cur.wen   = (cnt != '0);
            end
            default: ;
        endcase
    end

    // Edge rows see a dead neighbour row
    always_ff @(posedge clk) begin
        if (state == S_STEP_FETCH) begin
            case (phase)
                2'd1:    win_above <= (cnt == '0) ? '0 : cur.rdata;
                2'd2:    win_mid   <= cur.rdata;
                2'd3:    win_below <= (cnt == LAST_ROW) ? '0 : cur.rdata;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= S_IDLE;
            cnt      <= '0;
            phase    <= '0;
            rd_valid <= 1'b0;
            rd_data  <= '0;
        end else begin
            rd_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (cmd_valid) begin
                        cnt   <= '0;
                        phase <= '0;
                        case (cmd)
                            life_pkg::CMD_PRESET: state <= S_PRESET;
                            life_pkg::CMD_TOGGLE: state <= S_TGL_RD;
                            life_pkg::CMD_STEP:   state <= S_STEP_FETCH;
                            default:              state <= S_READ;
                        endcase
                    end
                end
                S_PRESET: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == LAST_ROW) state <= S_IDLE;
                end
                S_TGL_RD:   state <= S_TGL_WAIT;
                S_TGL_WAIT: state <= S_TGL_WR;
                S_TGL_WR:   state <= S_IDLE;
                S_STEP_FETCH: begin
                    phase <= phase + 1'b1;
                    if (phase == 2'd3) state <= S_STEP_WRITE;
                end
                S_STEP_WRITE: begin
                    if (cnt == LAST_ROW) begin
                        cnt   <= '0;
                        state <= S_COPY;
                    end else begin
                        cnt   <= cnt + 1'b1;
                        state <= S_STEP_FETCH;
                    end
                end
                S_COPY: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == ROW_END) state <= S_IDLE;
                end
                S_READ: begin
                    rd_valid <= 1'b1;
                    rd_data  <= cur.rdata;
                    state    <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- design/life_row_rule.sv
`timescale 1ns/1ps
`include "life_config.svh"

module life_row_rule (
    input  life_pkg::row_t above,
    input  life_pkg::row_t middle,
    input  life_pkg::row_t below,
    output life_pkg::row_t next
);
    // One dead cell of padding on each side
    logic [`LIFE_COLS+1:0] a_pad;
    logic [`LIFE_COLS+1:0] m_pad;
    logic [`LIFE_COLS+1:0] b_pad;

    assign a_pad = {1'b0, above, 1'b0};
    assign m_pad = {1'b0, middle, 1'b0};
    assign b_pad = {1'b0, below, 1'b0};

    // Bit i of a row is padded bit i+1, neighbours at i and i+2
    for (genvar i = 0; i < `LIFE_COLS; i++) begin : g_cell
        logic [3:0] nbr;

        assign nbr = 4'(a_pad[i]) + 4'(a_pad[i+1]) + 4'(a_pad[i+2])
                   + 4'(m_pad[i])                  + 4'(m_pad[i+2])
                   + 4'(b_pad[i]) + 4'(b_pad[i+1]) + 4'(b_pad[i+2]);

        assign next[i] = (nbr == 4'd3) || (middle[i] && nbr == 4'd2);
    end

endmodule

//--- design/preset_rom.sv
`timescale 1ns/1ps
`include "life_config.svh"

module preset_rom (
    input  life_pkg::preset_t   preset,
    input  life_pkg::row_addr_t row,
    output life_pkg::row_t      pattern
);
    // Puts a run of bits at the given first column, MSB first
    function automatic life_pkg::row_t place(input logic [6:0] bits, input int first,
                                             input int width);
        return life_pkg::row_t'(bits) << (`LIFE_COLS - first - width);
    endfunction

    always_comb begin
        pattern = '0;
        case (preset)
            life_pkg::PRESET_GLIDER: begin
                case (row)
                    5'd0:    pattern = place(7'b1, 1, 1);
                    5'd1:    pattern = place(7'b11, 2, 2);
                    5'd2:    pattern = place(7'b11, 1, 2);
                    default: pattern = '0;
                endcase
            end
            life_pkg::PRESET_EXPLODER: begin
                case (row)
                    5'd13, 5'd17:        pattern = place(7'b10101, 17, 5);
                    5'd14, 5'd15, 5'd16: pattern = place(7'b10001, 17, 5);
                    default:             pattern = '0;
                endcase
            end
            life_pkg::PRESET_TUMBLER: begin
                case (row)
                    5'd13, 5'd14: pattern = place(7'b11011, 17, 5);
                    5'd15:        pattern = place(7'b01010, 17, 5);
                    5'd16, 5'd17: pattern = place(7'b1010101, 16, 7);
                    5'd18:        pattern = place(7'b1100011, 16, 7);
                    default:      pattern = '0;
                endcase
            end
            default: pattern = '0;   // Clear and unused codes
        endcase
    end

endmodule

//--- design/cmd_front.sv
`timescale 1ns/1ps

module cmd_front (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                preset_load,
    input  logic                toggle,
    input  logic                step,
    input  logic                rd_en,
    input  life_pkg::preset_t   preset_sel,
    input  life_pkg::col_addr_t cell_x,
    input  life_pkg::row_addr_t cell_y,
    input  life_pkg::row_addr_t rd_row,
    input  logic                busy,
    output logic                cmd_valid,
    output life_pkg::cmd_t      cmd,
    output life_pkg::preset_t   preset,
    output life_pkg::col_addr_t col,
    output life_pkg::row_addr_t row
);
    logic accept;
    logic any_strobe;

    assign any_strobe = preset_load | toggle | step | rd_en;
    assign accept     = any_strobe && !busy && !cmd_valid; // Lost strobes are not queued

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= accept;
        end
    end

    // Operands stay put until the next accepted command
    always_ff @(posedge clk) begin
        if (accept) begin
            preset <= preset_sel;
            col    <= cell_x;
            if (preset_load) begin
                cmd <= life_pkg::CMD_PRESET;
            end else if (toggle) begin
                cmd <= life_pkg::CMD_TOGGLE;
                row <= cell_y;
            end else if (step) begin
                cmd <= life_pkg::CMD_STEP;
            end else begin
                cmd <= life_pkg::CMD_READ;
                row <= rd_row;
            end
        end
    end

endmodule

//--- design/row_ram.sv
`timescale 1ns/1ps
`include "life_config.svh"

module row_ram (
    input logic clk,
    grid_if.mem bus
);
    life_pkg::row_t cells [`LIFE_ROWS];

    always_ff @(posedge clk) begin
        if (bus.wen) begin
            cells[bus.addr] <= bus.wdata;
        end
    end

    // Registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        bus.rdata <= cells[bus.addr];
    end

endmodule

//--- design/grid_if.sv
`timescale 1ns/1ps

interface grid_if;
    life_pkg::row_addr_t addr;
    life_pkg::row_t      wdata;
    logic                wen;
    life_pkg::row_t      rdata;   // Word at the previous cycle's addr

    modport master (
        output addr, wdata, wen,
        input  rdata
    );

    modport mem (
        input  addr, wdata, wen,
        output rdata
    );
endinterface

//--- design/life_pkg.sv
`include "life_config.svh"

package life_pkg;

    // Column 0 sits at the MSB
    typedef logic [`LIFE_COLS-1:0]  row_t;
    typedef logic [`LIFE_ROW_W-1:0] row_addr_t;
    typedef logic [`LIFE_COL_W-1:0] col_addr_t;

    // Codes 4 to 7 load as clear
    typedef enum logic [2:0] {
        PRESET_CLEAR    = 3'd0,
        PRESET_GLIDER   = 3'd1,
        PRESET_EXPLODER = 3'd2,
        PRESET_TUMBLER  = 3'd3
    } preset_t;

    typedef enum logic [1:0] {
        CMD_PRESET = 2'd0,
        CMD_TOGGLE = 2'd1,
        CMD_STEP   = 2'd2,
        CMD_READ   = 2'd3
    } cmd_t;

endpackage

//--- design/life_config.svh
`ifndef LIFE_CONFIG_SVH
`define LIFE_CONFIG_SVH

// Grid geometry, one 40-bit word per row
`define LIFE_COLS  40
`define LIFE_ROWS  30

// Index widths
`define LIFE_COL_W 6
`define LIFE_ROW_W 5

`endif
